// File: rtl/sound_pkg.sv
`default_nettype none

package sound_pkg;

    // One codec word per channel
    typedef logic signed [31:0] sample_t;

    typedef logic [18:0] half_period_t;   // Clock cycles per tone half-period

    typedef logic amp_sel_t;

    localparam amp_sel_t AMP_SEL_TITLE     = 1'b0;
    localparam amp_sel_t AMP_SEL_COUNTDOWN = 1'b1;

    localparam sample_t TITLE_AMP     = 32'sd60000000;
    localparam sample_t COUNTDOWN_AMP = 32'sd50000000;   // Slightly softer beeps

    // Title notes in the sixth octave and above
    localparam half_period_t NOTE_C6 = 19'd23889;   // ~1046 Hz
    localparam half_period_t NOTE_E6 = 19'd18968;   // ~1318 Hz
    localparam half_period_t NOTE_G6 = 19'd15944;   // ~1568 Hz
    localparam half_period_t NOTE_A6 = 19'd14205;   // ~1760 Hz
    localparam half_period_t NOTE_C7 = 19'd11945;   // ~2093 Hz

    // Fixed pitch of every countdown beep
    localparam half_period_t BEEP_PERIOD = 19'd40000;

endpackage

`default_nettype wire

// File: rtl/cue_pkg.sv
`default_nettype none

package cue_pkg;

    typedef logic [31:0] cycles_t;      // Duration counters
    typedef logic [4:0]  step_t;        // Title step 0 to 16
    typedef logic [4:0]  loop_t;
    typedef logic [2:0]  beep_count_t;

    localparam step_t       TITLE_STEPS     = 5'd17;
    localparam beep_count_t COUNTDOWN_BEEPS = 3'd6;   // Five beeps plus GO

    // Arpeggio for steps 0 to 15
    // Step 16 falls back to the root note
    localparam sound_pkg::half_period_t TITLE_MELODY [16] = '{
        sound_pkg::NOTE_C6,
        sound_pkg::NOTE_E6,
        sound_pkg::NOTE_G6,
        sound_pkg::NOTE_C7,
        sound_pkg::NOTE_A6,
        sound_pkg::NOTE_G6,
        sound_pkg::NOTE_E6,
        sound_pkg::NOTE_C7,
        sound_pkg::NOTE_C6,
        sound_pkg::NOTE_E6,
        sound_pkg::NOTE_G6,
        sound_pkg::NOTE_C7,
        sound_pkg::NOTE_A6,
        sound_pkg::NOTE_G6,
        sound_pkg::NOTE_E6,
        sound_pkg::NOTE_C7
    };

    typedef enum logic [2:0] {
        IDLE,
        TITLE,
        COUNTDOWN,
        TITLE_DONE,
        COUNTDOWN_DONE
    } cue_state_t;

endpackage

`default_nettype wire

// File: rtl/cue_if.sv
`timescale 1ns/1ps
`default_nettype none

// Link between the controller and one cue sequencer
interface seq_if;

    logic                    run;           // Level, held while the cue plays
    logic                    gate;          // Note or beep sounding
    sound_pkg::half_period_t half_period;
    logic                    finished;

    modport ctrl (
        output run,
        input  gate,
        input  half_period,
        input  finished
    );

    modport seq (
        input  run,
        output gate,
        output half_period,
        output finished
    );

endinterface

// Registered tone request to the oscillator
interface tone_if;

    logic                    gate;
    sound_pkg::half_period_t half_period;
    sound_pkg::amp_sel_t     amp_sel;

    modport ctrl (
        output gate,
        output half_period,
        output amp_sel
    );

    modport osc (
        input gate,
        input half_period,
        input amp_sel
    );

endinterface

`default_nettype wire

// File: rtl/cue_controller.sv
`timescale 1ns/1ps
`default_nettype none

module cue_controller (
    input  logic CLOCK_50,
    input  logic rst_n,
    input  logic enable_title,
    input  logic enable_countdown,
    seq_if.ctrl  title_seq,
    seq_if.ctrl  count_seq,
    tone_if.ctrl tone,
    output logic title_done,
    output logic playing
);

    cue_pkg::cue_state_t state;
    cue_pkg::cue_state_t state_next;

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            state <= cue_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Title wins whenever both enables are high
    always_comb begin
        state_next = state;
        case (state)
            cue_pkg::IDLE: begin
                if (enable_title) begin
                    state_next = cue_pkg::TITLE;
                end else if (enable_countdown) begin
                    state_next = cue_pkg::COUNTDOWN;
                end
            end
            cue_pkg::TITLE: begin
                if (!enable_title) begin
                    state_next = cue_pkg::IDLE;
                end else if (title_seq.finished) begin
                    state_next = cue_pkg::TITLE_DONE;
                end
            end
            cue_pkg::COUNTDOWN: begin
                if (enable_title) begin
                    state_next = cue_pkg::TITLE;
                end else if (!enable_countdown) begin
                    state_next = cue_pkg::IDLE;
                end else if (count_seq.finished) begin
                    state_next = cue_pkg::COUNTDOWN_DONE;
                end
            end
            cue_pkg::TITLE_DONE: begin
                if (!enable_title) begin
                    state_next = cue_pkg::IDLE;   // Done flag clears here
                end
            end
            cue_pkg::COUNTDOWN_DONE: begin
                if (enable_title) begin
                    state_next = cue_pkg::TITLE;
                end else if (!enable_countdown) begin
                    state_next = cue_pkg::IDLE;
                end
            end
            default: state_next = cue_pkg::IDLE;
        endcase
    end

    assign title_seq.run = (state == cue_pkg::TITLE);
    assign count_seq.run = (state == cue_pkg::COUNTDOWN);
    assign title_done    = (state == cue_pkg::TITLE_DONE);
    assign playing       = (state == cue_pkg::TITLE) || (state == cue_pkg::COUNTDOWN);

    // Gate of the active cue, one cycle behind the sequencer
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            tone.gate <= 1'b0;
        end else begin
            case (state)
                cue_pkg::TITLE:     tone.gate <= title_seq.gate;
                cue_pkg::COUNTDOWN: tone.gate <= count_seq.gate;
                default:            tone.gate <= 1'b0;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (state == cue_pkg::COUNTDOWN) begin
            tone.half_period <= count_seq.half_period;
            tone.amp_sel     <= sound_pkg::AMP_SEL_COUNTDOWN;
        end else begin
            tone.half_period <= title_seq.half_period;
            tone.amp_sel     <= sound_pkg::AMP_SEL_TITLE;
        end
    end

endmodule

`default_nettype wire

// File: rtl/title_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module title_sequencer #(
    parameter cue_pkg::cycles_t PATTERN_CYCLES  = 12500000,
    parameter cue_pkg::cycles_t NOTE_GAP_CYCLES = 1000000,
    parameter cue_pkg::loop_t   TITLE_LOOPS     = 30
) (
    input  logic           CLOCK_50,
    input  logic           rst_n,
    seq_if.seq             seq,
    output cue_pkg::step_t title_step
);

    cue_pkg::cycles_t        pattern_timer;
    cue_pkg::cycles_t        note_timer;
    cue_pkg::step_t          step;
    cue_pkg::loop_t          loop_count;
    sound_pkg::half_period_t note;
    logic                    note_on;
    logic                    finished;
    logic                    boundary;
    logic                    last_step;
    logic                    last_loop;

    // Timer at zero means a fresh run, so the first boundary comes at once
    assign boundary  = (pattern_timer == '0) || (pattern_timer >= PATTERN_CYCLES);
    assign last_step = (step == cue_pkg::step_t'(cue_pkg::TITLE_STEPS - 1'b1));
    assign last_loop = (loop_count == cue_pkg::loop_t'(TITLE_LOOPS - 1'b1));

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            pattern_timer <= '0;
            note_timer    <= '0;
            step          <= '0;
            loop_count    <= '0;
            note_on       <= 1'b0;
            finished      <= 1'b0;
        end else if (!seq.run) begin
            pattern_timer <= '0;
            note_timer    <= '0;
            step          <= '0;
            loop_count    <= '0;
            note_on       <= 1'b0;
            finished      <= 1'b0;
        end else begin
            finished <= 1'b0;

            // Short note then gap, over and over within a pattern
            if (note_timer >= NOTE_GAP_CYCLES) begin
                note_timer <= '0;
                note_on    <= ~note_on;
            end else begin
                note_timer <= note_timer + 1'b1;
            end

            if (boundary) begin
                pattern_timer <= cue_pkg::cycles_t'(1);
                note_timer    <= '0;
                note_on       <= 1'b1;          // Each pattern opens on a note
                if (last_step) begin
                    step <= '0;
                    if (last_loop) begin
                        finished <= 1'b1;
                        note_on  <= 1'b0;       // Jingle ends silent
                    end else begin
                        loop_count <= loop_count + 1'b1;
                    end
                end else begin
                    step <= step + 1'b1;
                end
            end else begin
                pattern_timer <= pattern_timer + 1'b1;
            end
        end
    end

    // Note of the step being left
    always_ff @(posedge CLOCK_50) begin
        if (seq.run && boundary) begin
            note <= last_step ? sound_pkg::NOTE_C6 : cue_pkg::TITLE_MELODY[step[3:0]];
        end
    end

    assign seq.gate        = note_on;
    assign seq.half_period = note;
    assign seq.finished    = finished;
    assign title_step      = step;

endmodule

`default_nettype wire

// File: rtl/countdown_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module countdown_sequencer #(
    parameter cue_pkg::cycles_t BEEP_CYCLES     = 25000000,
    parameter cue_pkg::cycles_t BEEP_GAP_CYCLES = 15000000,
    parameter cue_pkg::cycles_t GO_BEEP_CYCLES  = 35000000
) (
    input  logic CLOCK_50,
    input  logic rst_n,
    seq_if.seq   seq
);

    cue_pkg::cycles_t     timer;        // Counts down the current beep or gap
    cue_pkg::beep_count_t beeps;        // Beeps started so far
    logic                 beep_on;
    logic                 done;
    logic                 go_next;

    assign go_next = (beeps == cue_pkg::COUNTDOWN_BEEPS - 1'b1);

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            timer   <= '0;
            beeps   <= '0;
            beep_on <= 1'b0;
            done    <= 1'b0;
        end else if (!seq.run) begin
            timer   <= '0;
            beeps   <= '0;
            beep_on <= 1'b0;
            done    <= 1'b0;
        end else if (timer != '0) begin
            timer <= timer - 1'b1;
        end else if (beep_on) begin
            // Every beep is followed by a gap, GO included
            beep_on <= 1'b0;
            timer   <= BEEP_GAP_CYCLES;
        end else if (beeps == cue_pkg::COUNTDOWN_BEEPS) begin
            done <= 1'b1;                   // Held until run drops
        end else begin
            beep_on <= 1'b1;
            beeps   <= beeps + 1'b1;
            timer   <= go_next ? GO_BEEP_CYCLES : BEEP_CYCLES;
        end
    end

    assign seq.gate        = beep_on;
    assign seq.half_period = sound_pkg::BEEP_PERIOD;
    assign seq.finished    = done;

endmodule

`default_nettype wire

// File: rtl/tone_oscillator.sv
`timescale 1ns/1ps
`default_nettype none

module tone_oscillator #(
    parameter int PERIOD_SHIFT = 0
) (
    input  logic               CLOCK_50,
    input  logic               rst_n,
    tone_if.osc                tone,
    output sound_pkg::sample_t wave
);

    sound_pkg::half_period_t limit;
    sound_pkg::half_period_t count;
    sound_pkg::sample_t      amp;
    logic                    snd;       // Square wave polarity

    assign limit = tone.half_period >> PERIOD_SHIFT;

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            snd   <= 1'b0;
        end else if (!tone.gate) begin
            // Restart so every note begins on the same phase
            count <= '0;
            snd   <= 1'b0;
        end else if (count >= limit) begin
            count <= '0;
            snd   <= ~snd;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign amp = (tone.amp_sel == sound_pkg::AMP_SEL_TITLE) ? sound_pkg::TITLE_AMP
                                                            : sound_pkg::COUNTDOWN_AMP;

    assign wave = !tone.gate ? '0 : (snd ? amp : -amp);   // Silent between notes

endmodule

`default_nettype wire

// File: rtl/sample_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_mixer (
    input  logic               CLOCK_50,
    input  logic               rst_n,
    input  logic               audio_in_available,
    input  logic               audio_out_allowed,
    input  sound_pkg::sample_t left_in,
    input  sound_pkg::sample_t right_in,
    input  sound_pkg::sample_t wave,
    output sound_pkg::sample_t left_out,
    output sound_pkg::sample_t right_out,
    output logic               read_audio_in,
    output logic               write_audio_out
);

    logic accept;

    // A sample moves only when the codec can both give and take
    assign accept        = audio_in_available & audio_out_allowed;
    assign read_audio_in = accept;

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            write_audio_out <= 1'b0;
            left_out        <= '0;
            right_out       <= '0;
        end else begin
            write_audio_out <= accept;
            if (accept) begin
                left_out  <= left_in + wave;    // Wraps like the codec word
                right_out <= right_in + wave;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/audio_cue_top.sv
`timescale 1ns/1ps
`default_nettype none

module audio_cue_top #(
    parameter cue_pkg::cycles_t PATTERN_CYCLES  = 12500000,
    parameter cue_pkg::cycles_t NOTE_GAP_CYCLES = 1000000,
    parameter cue_pkg::loop_t   TITLE_LOOPS     = 30,
    parameter cue_pkg::cycles_t BEEP_CYCLES     = 25000000,
    parameter cue_pkg::cycles_t BEEP_GAP_CYCLES = 15000000,
    parameter cue_pkg::cycles_t GO_BEEP_CYCLES  = 35000000,
    parameter int               PERIOD_SHIFT    = 0
) (
    input  logic               CLOCK_50,
    input  logic               rst_n,
    input  logic               enable_title,
    input  logic               enable_countdown,
    input  logic               audio_in_available,
    input  logic               audio_out_allowed,
    input  sound_pkg::sample_t left_in,
    input  sound_pkg::sample_t right_in,
    output sound_pkg::sample_t left_out,
    output sound_pkg::sample_t right_out,
    output logic               read_audio_in,
    output logic               write_audio_out,
    output logic               title_done,
    output logic               playing,
    output cue_pkg::step_t     title_step
);

    seq_if  title_bus ();
    seq_if  count_bus ();
    tone_if tone_bus ();

    sound_pkg::sample_t tone;   // Oscillator output into the mixer

    cue_controller cue_controller_inst (
        .CLOCK_50         (CLOCK_50),
        .rst_n            (rst_n),
        .enable_title     (enable_title),
        .enable_countdown (enable_countdown),
        .title_seq        (title_bus.ctrl),
        .count_seq        (count_bus.ctrl),
        .tone             (tone_bus.ctrl),
        .title_done       (title_done),
        .playing          (playing)
    );

    title_sequencer #(
        .PATTERN_CYCLES  (PATTERN_CYCLES),
        .NOTE_GAP_CYCLES (NOTE_GAP_CYCLES),
        .TITLE_LOOPS     (TITLE_LOOPS)
    ) title_sequencer_inst (
        .CLOCK_50   (CLOCK_50),
        .rst_n      (rst_n),
        .seq        (title_bus.seq),
        .title_step (title_step)
    );

    countdown_sequencer #(
        .BEEP_CYCLES     (BEEP_CYCLES),
        .BEEP_GAP_CYCLES (BEEP_GAP_CYCLES),
        .GO_BEEP_CYCLES  (GO_BEEP_CYCLES)
    ) countdown_sequencer_inst (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .seq      (count_bus.seq)
    );

    tone_oscillator #(
        .PERIOD_SHIFT (PERIOD_SHIFT)
    ) tone_oscillator_inst (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .tone     (tone_bus.osc),
        .wave     (tone)
    );

    sample_mixer sample_mixer_inst (
        .CLOCK_50           (CLOCK_50),
        .rst_n              (rst_n),
        .audio_in_available (audio_in_available),
        .audio_out_allowed  (audio_out_allowed),
        .left_in            (left_in),
        .right_in           (right_in),
        .wave               (tone),
        .left_out           (left_out),
        .right_out          (right_out),
        .read_audio_in      (read_audio_in),
        .write_audio_out    (write_audio_out)
    );

endmodule

`default_nettype wire

// File: testbench/audio_cue_props.sv
`timescale 1ns/1ps
`default_nettype none

module audio_cue_props (
    input logic               CLOCK_50,
    input logic               rst_n,
    input logic               audio_in_available,
    input logic               audio_out_allowed,
    input logic               write_audio_out,
    input logic               playing,
    input logic               title_done,
    input sound_pkg::sample_t left_out,
    input sound_pkg::sample_t right_out
);

    // Write strobe only for a sample taken on the edge before
    write_follows_accept: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        write_audio_out |-> $past(audio_in_available && audio_out_allowed))
        else $error("write_audio_out without an accepted sample");

    done_excludes_playing: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        !(playing && title_done))
        else $error("playing and title_done high together");

    outputs_hold: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        !write_audio_out |-> ($stable(left_out) && $stable(right_out)))
        else $error("Output samples changed without a write strobe");

endmodule

bind audio_cue_top audio_cue_props audio_cue_props_inst (
    .CLOCK_50           (CLOCK_50),
    .rst_n              (rst_n),
    .audio_in_available (audio_in_available),
    .audio_out_allowed  (audio_out_allowed),
    .write_audio_out    (write_audio_out),
    .playing            (playing),
    .title_done         (title_done),
    .left_out           (left_out),
    .right_out          (right_out)
);

`default_nettype wire

// File: testbench/audio_cue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module audio_cue_tb;

    // Short durations so a full jingle fits in a few thousand cycles
    localparam cue_pkg::cycles_t PATTERN_CYCLES  = 40;
    localparam cue_pkg::cycles_t NOTE_GAP_CYCLES = 9;
    localparam cue_pkg::loop_t   TITLE_LOOPS     = 2;
    localparam cue_pkg::cycles_t BEEP_CYCLES     = 30;
    localparam cue_pkg::cycles_t BEEP_GAP_CYCLES = 20;
    localparam cue_pkg::cycles_t GO_BEEP_CYCLES  = 50;
    localparam int               PERIOD_SHIFT    = 12;
    localparam int               TIMEOUT         = 4000;   // Cycles per wait

    logic               CLOCK_50;
    logic               rst_n;
    logic               enable_title;
    logic               enable_countdown;
    logic               audio_in_available;
    logic               audio_out_allowed;
    sound_pkg::sample_t left_in;
    sound_pkg::sample_t right_in;
    sound_pkg::sample_t left_out;
    sound_pkg::sample_t right_out;
    logic               read_audio_in;
    logic               write_audio_out;
    logic               title_done;
    logic               playing;
    cue_pkg::step_t     title_step;

    int                 errors;
    int                 errors_before;
    int                 tests_run;
    sound_pkg::sample_t prev_left;      // Last samples driven into the DUT
    sound_pkg::sample_t prev_right;
    sound_pkg::sample_t diff_left;      // Output minus the matching input
    sound_pkg::sample_t diff_right;

    audio_cue_top #(
        .PATTERN_CYCLES  (PATTERN_CYCLES),
        .NOTE_GAP_CYCLES (NOTE_GAP_CYCLES),
        .TITLE_LOOPS     (TITLE_LOOPS),
        .BEEP_CYCLES     (BEEP_CYCLES),
        .BEEP_GAP_CYCLES (BEEP_GAP_CYCLES),
        .GO_BEEP_CYCLES  (GO_BEEP_CYCLES),
        .PERIOD_SHIFT    (PERIOD_SHIFT)
    ) audio_cue_top_inst (
        .CLOCK_50           (CLOCK_50),
        .rst_n              (rst_n),
        .enable_title       (enable_title),
        .enable_countdown   (enable_countdown),
        .audio_in_available (audio_in_available),
        .audio_out_allowed  (audio_out_allowed),
        .left_in            (left_in),
        .right_in           (right_in),
        .left_out           (left_out),
        .right_out          (right_out),
        .read_audio_in      (read_audio_in),
        .write_audio_out    (write_audio_out),
        .title_done         (title_done),
        .playing            (playing),
        .title_step         (title_step)
    );

    always #4 CLOCK_50 = ~CLOCK_50;

    task automatic compare_sample(input string name, input sound_pkg::sample_t got,
                                  input sound_pkg::sample_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_step(input string name, input cue_pkg::step_t got,
                                input cue_pkg::step_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("Test %-24s %s", name, (errors == errors_before) ? "ok" : "had errors");
    endtask

    // Silence or plus/minus the given amplitude, nothing else
    task automatic check_tone(input string name, input sound_pkg::sample_t diff,
                              input sound_pkg::sample_t amp);
        sound_pkg::sample_t exp;
        exp = amp;
        if (diff == -amp || diff == '0) begin
            exp = diff;
        end
        compare_sample(name, diff, exp);
    endtask

    // Reads the outputs, then drives a fresh random sample pair
    task automatic sample_cycle();
        @(negedge CLOCK_50);
        diff_left  = left_out - prev_left;
        diff_right = right_out - prev_right;
        prev_left  = $urandom;
        prev_right = $urandom;
        left_in    = prev_left;
        right_in   = prev_right;
    endtask

    task automatic check_quiet_outputs();
        compare_bit("write_audio_out", write_audio_out, 1'b0);
        compare_bit("read_audio_in", read_audio_in, 1'b0);
        compare_bit("playing", playing, 1'b0);
        compare_bit("title_done", title_done, 1'b0);
    endtask

    task automatic check_reset();
        errors_before = errors;
        rst_n = 1'b0;
        repeat (3) begin
            @(negedge CLOCK_50);
            check_quiet_outputs();
        end
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge CLOCK_50);
            check_quiet_outputs();
        end
        finish_test("reset");
    endtask

    task automatic pass_through_and_backpressure();
        sound_pkg::sample_t hold_left;
        sound_pkg::sample_t hold_right;
        errors_before = errors;
        audio_in_available = 1'b1;
        audio_out_allowed  = 1'b1;
        sample_cycle();
        repeat (40) begin
            sample_cycle();
            compare_bit("write_audio_out", write_audio_out, 1'b1);
            compare_bit("read_audio_in", read_audio_in, 1'b1);
            compare_sample("left_out - left_in", diff_left, '0);
            compare_sample("right_out - right_in", diff_right, '0);
        end
        hold_left  = left_out;      // Sample driven this edge is never taken
        hold_right = right_out;
        audio_out_allowed = 1'b0;
        repeat (10) begin
            @(negedge CLOCK_50);
            compare_bit("read_audio_in", read_audio_in, 1'b0);
            compare_bit("write_audio_out", write_audio_out, 1'b0);
            compare_sample("left_out", left_out, hold_left);
            compare_sample("right_out", right_out, hold_right);
            prev_left  = $urandom;
            prev_right = $urandom;
            left_in    = prev_left;
            right_in   = prev_right;
        end
        audio_out_allowed = 1'b1;
        sample_cycle();
        finish_test("pass-through");
    endtask

    task automatic title_playback();
        cue_pkg::step_t last_step;
        cue_pkg::step_t next_step;
        int             moves;
        int             tone_samples;
        int             cycles;
        errors_before = errors;
        moves        = 0;
        tone_samples = 0;
        cycles       = 0;
        enable_title = 1'b1;
        sample_cycle();
        last_step = title_step;
        while (!title_done && cycles < TIMEOUT) begin
            compare_bit("playing", playing, 1'b1);
            check_tone("left_out - left_in", diff_left, sound_pkg::TITLE_AMP);
            check_tone("right_out - right_in", diff_right, sound_pkg::TITLE_AMP);
            if (diff_left != '0) begin
                tone_samples++;
            end
            if (title_step != last_step) begin
                next_step = last_step + 1'b1;
                if (last_step == cue_pkg::TITLE_STEPS - 1'b1) begin
                    next_step = '0;     // Wraps after step 16
                end
                compare_step("title_step", title_step, next_step);
                last_step = title_step;
                moves++;
            end
            sample_cycle();
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            report_problem("Timed out waiting for title_done to rise");
        end
        if (moves != int'(cue_pkg::TITLE_STEPS) * int'(TITLE_LOOPS)) begin
            report_problem($sformatf("title_step moved %0d times, not %0d",
                                     moves, int'(cue_pkg::TITLE_STEPS) * int'(TITLE_LOOPS)));
        end
        if (tone_samples == 0) begin
            report_problem("No title tone reached the outputs");
        end
        sample_cycle();     // Last gated sample may still be in flight
        repeat (20) begin
            sample_cycle();
            compare_bit("playing", playing, 1'b0);
            compare_bit("title_done", title_done, 1'b1);
            compare_sample("left_out - left_in", diff_left, '0);
            compare_sample("right_out - right_in", diff_right, '0);
        end
        finish_test("title playback");
    endtask

    task automatic done_clear_and_restart();
        int cycles;
        errors_before = errors;
        enable_title = 1'b0;
        cycles = 0;
        sample_cycle();
        compare_bit("title_done", title_done, 1'b0);    // One cycle after the enable drops
        while (title_done && cycles < TIMEOUT) begin
            sample_cycle();
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            report_problem("Timed out waiting for title_done to clear");
        end
        compare_bit("playing", playing, 1'b0);
        enable_title = 1'b1;
        cycles = 0;
        sample_cycle();
        while (title_step == '0 && cycles < TIMEOUT) begin
            sample_cycle();
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            report_problem("Jingle did not restart after enable_title rose again");
        end
        compare_bit("playing", playing, 1'b1);
        compare_bit("title_done", title_done, 1'b0);
        enable_title = 1'b0;
        cycles = 0;
        sample_cycle();
        while (playing && cycles < TIMEOUT) begin
            sample_cycle();
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            report_problem("Timed out waiting for playing to fall");
        end
        sample_cycle();
        compare_step("title_step", title_step, '0);
        finish_test("done clear");
    endtask

    task automatic countdown_beeps();
        int run_lens[$];
        int run_len;
        int silent_after;
        int cycles;
        errors_before = errors;
        run_len      = 0;
        silent_after = 0;
        cycles       = 0;
        enable_countdown = 1'b1;
        sample_cycle();
        while (playing && cycles < TIMEOUT) begin
            check_tone("left_out - left_in", diff_left, sound_pkg::COUNTDOWN_AMP);
            check_tone("right_out - right_in", diff_right, sound_pkg::COUNTDOWN_AMP);
            if (diff_left != '0) begin
                run_len++;
            end else if (run_len != 0) begin
                run_lens.push_back(run_len);    // One beep closed
                run_len = 0;
            end else if (run_lens.size() == int'(cue_pkg::COUNTDOWN_BEEPS)) begin
                silent_after++;
            end
            sample_cycle();
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            report_problem("Timed out waiting for the countdown to finish");
        end
        if (run_lens.size() != int'(cue_pkg::COUNTDOWN_BEEPS)) begin
            report_problem($sformatf("Countdown gave %0d beeps instead of %0d",
                                     run_lens.size(), cue_pkg::COUNTDOWN_BEEPS));
        end else begin
            for (int i = 0; i < 5; i++) begin
                if (run_lens[i] != int'(BEEP_CYCLES) + 1) begin
                    report_problem($sformatf("Beep %0d lasted %0d samples", i, run_lens[i]));
                end
                if (run_lens[5] <= run_lens[i]) begin
                    report_problem($sformatf("GO beep is not longer than beep %0d", i));
                end
            end
            if (run_lens[5] != int'(GO_BEEP_CYCLES) + 1) begin
                report_problem($sformatf("GO beep lasted %0d samples", run_lens[5]));
            end
        end
        if (silent_after == 0) begin
            report_problem("No silence after the GO beep while the countdown was playing");
        end
        repeat (5) begin
            sample_cycle();
            compare_sample("left_out - left_in", diff_left, '0);
            compare_bit("title_done", title_done, 1'b0);
        end
        enable_countdown = 1'b0;
        repeat (2) sample_cycle();
        finish_test("countdown");
    endtask

    task automatic title_priority();
        int tone_samples;
        int cycles;
        errors_before = errors;
        tone_samples     = 0;
        enable_title     = 1'b1;
        enable_countdown = 1'b1;
        sample_cycle();
        repeat (200) begin
            sample_cycle();
            compare_bit("playing", playing, 1'b1);
            check_tone("left_out - left_in", diff_left, sound_pkg::TITLE_AMP);
            check_tone("right_out - right_in", diff_right, sound_pkg::TITLE_AMP);
            if (diff_left != '0) begin
                tone_samples++;
            end
        end
        if (tone_samples == 0) begin
            report_problem("No tone with both cues enabled");
        end
        enable_title     = 1'b0;
        enable_countdown = 1'b0;
        cycles = 0;
        sample_cycle();
        while (playing && cycles < TIMEOUT) begin
            sample_cycle();
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            report_problem("Timed out waiting for playing to fall");
        end
        finish_test("priority");
    endtask

    initial begin
        CLOCK_50           = 1'b0;
        rst_n              = 1'b0;
        enable_title       = 1'b0;
        enable_countdown   = 1'b0;
        audio_in_available = 1'b0;
        audio_out_allowed  = 1'b0;
        left_in            = '0;
        right_in           = '0;
        prev_left          = '0;
        prev_right         = '0;
        errors             = 0;
        tests_run          = 0;
        void'($urandom(32'h0d3b3fd9));

        check_reset();
        pass_through_and_backpressure();
        title_playback();
        done_clear_and_restart();
        countdown_beeps();
        title_priority();

        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
rtl/sound_pkg.sv
rtl/cue_pkg.sv
rtl/cue_if.sv
rtl/cue_controller.sv
rtl/title_sequencer.sv
rtl/countdown_sequencer.sv
rtl/tone_oscillator.sv
rtl/sample_mixer.sv
rtl/audio_cue_top.sv
testbench/audio_cue_props.sv
testbench/audio_cue_tb.sv
